/* logic/mac_pkg.sv */
// Shared types for the multiply-add execution pipe.
// Covers operand words, tags, opcodes, rounding modes and the packets passed from
// the dispatch decoder through both pipes to the result merge.
// RTL and testbench refer to these by scoped name.
package mac_pkg;

  // one operand or result word
  typedef logic [31:0] data_t;

  // dispatch tag, carried back with the result
  typedef logic [3:0] tag_t;

  // fraction bits of the wide Q16.16 format; the narrow Q8.8 format uses half
  localparam int FRAC_W = 16;

  typedef enum logic [2:0] {
    e_op_fadd   = 3'd0,
    e_op_fsub   = 3'd1,
    e_op_fmul   = 3'd2,
    e_op_fmadd  = 3'd3,
    e_op_fmsub  = 3'd4,
    e_op_fnmsub = 3'd5,
    e_op_fnmadd = 3'd6,
    e_op_imul   = 3'd7
  } mac_op_e;

  // encodings follow the RISC-V frm field, dyn defers to the dynamic mode input
  typedef enum logic [2:0] {
    e_rne = 3'b000,
    e_rtz = 3'b001,
    e_rdn = 3'b010,
    e_rup = 3'b011,
    e_dyn = 3'b111
  } rm_e;

  // multiply-add control
  //   no_addend=1           : (a x b)
  //   neg_prod=0 neg_addend=0 :   (a x b) + c
  //   neg_prod=0 neg_addend=1 :   (a x b) - c
  //   neg_prod=1 neg_addend=0 : - (a x b) + c
  //   neg_prod=1 neg_addend=1 : - (a x b) - c
  typedef struct packed {
    logic no_addend;
    logic neg_prod;
    logic neg_addend;
  } fma_ctl_t;

  typedef struct packed {
    logic inexact;
    logic overflow;
  } flags_t;

  typedef struct packed {
    mac_op_e op;
    rm_e     rm;
    logic    narrow;
    tag_t    tag;
    data_t   rs1;
    data_t   rs2;
    data_t   rs3;
  } dispatch_pkt_t;

  typedef struct packed {
    fma_ctl_t ctl;
    rm_e      rm;
    logic     narrow;
    tag_t     tag;
    data_t    a;
    data_t    b;
    data_t    c;
  } fma_req_t;

  typedef struct packed {
    logic  word;
    tag_t  tag;
    data_t a;
    data_t b;
  } imul_req_t;

  typedef struct packed {
    tag_t   tag;
    data_t  data;
    flags_t flags;
  } pipe_res_t;

endpackage

/* logic/dispatch_decode.sv */
// Dispatch decoder for the multiply-add pipe.
// Steers each packet to the fixed-point or integer pipe, resolves the rounding
// mode and builds the a, b, c operands and sign control. Purely combinational.
module dispatch_decode (
  input  mac_pkg::dispatch_pkt_t pkt_i,
  input  logic                   valid_i,
  input  mac_pkg::rm_e           frm_dyn_i,
  output logic                   fma_valid_o,
  output mac_pkg::fma_req_t      fma_req_o,
  output logic                   imul_valid_o,
  output mac_pkg::imul_req_t     imul_req_o
);

  // the constant one in each format, used as b for add and sub
  localparam mac_pkg::data_t ONE_WIDE   = mac_pkg::data_t'(1 << mac_pkg::FRAC_W);
  localparam mac_pkg::data_t ONE_NARROW = mac_pkg::data_t'(1 << (mac_pkg::FRAC_W / 2));

  logic           is_imul;
  mac_pkg::data_t one;

  assign is_imul = (pkt_i.op == mac_pkg::e_op_imul);
  assign one     = pkt_i.narrow ? ONE_NARROW : ONE_WIDE;

  assign fma_valid_o  = valid_i & ~is_imul;
  assign imul_valid_o = valid_i & is_imul;

  always_comb
  begin
    fma_req_o.ctl    = '0;
    fma_req_o.rm     = (pkt_i.rm == mac_pkg::e_dyn) ? frm_dyn_i : pkt_i.rm;
    fma_req_o.narrow = pkt_i.narrow;
    fma_req_o.tag    = pkt_i.tag;
    fma_req_o.a      = pkt_i.rs1;
    fma_req_o.b      = pkt_i.rs2;
    fma_req_o.c      = pkt_i.rs3;
    case (pkt_i.op)
      mac_pkg::e_op_fadd:
      begin
        fma_req_o.b = one;
        fma_req_o.c = pkt_i.rs2;
      end
      mac_pkg::e_op_fsub:
      begin
        fma_req_o.ctl.neg_addend = 1'b1;
        fma_req_o.b              = one;
        fma_req_o.c              = pkt_i.rs2;
      end
      mac_pkg::e_op_fmul:
      begin
        fma_req_o.ctl.no_addend = 1'b1;
        fma_req_o.c             = '0;
      end
      mac_pkg::e_op_fmsub:
        fma_req_o.ctl.neg_addend = 1'b1;
      mac_pkg::e_op_fnmsub:
        fma_req_o.ctl.neg_prod = 1'b1;
      mac_pkg::e_op_fnmadd:
      begin
        fma_req_o.ctl.neg_prod   = 1'b1;
        fma_req_o.ctl.neg_addend = 1'b1;
      end
      // fmadd keeps the defaults, imul is not routed here
      default:
        fma_req_o.ctl = '0;
    endcase
  end

  // the width flag doubles as word mode for the integer multiply
  assign imul_req_o.word = pkt_i.narrow;
  assign imul_req_o.tag  = pkt_i.tag;
  assign imul_req_o.a    = pkt_i.rs1;
  assign imul_req_o.b    = pkt_i.rs2;

endmodule

/* logic/pipe_delay.sv */
// Register chain that delays a payload and its valid by STAGES cycles.
// Several items may be in flight at once; only the valid bits are reset.
module pipe_delay #(
  parameter int STAGES = 1,
  parameter int WIDTH  = 1
) (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             valid_i,
  input  logic [WIDTH-1:0] data_i,
  output logic             valid_o,
  output logic [WIDTH-1:0] data_o
);

  if (STAGES == 0)
  begin : g_bypass
    assign valid_o = valid_i;
    assign data_o  = data_i;
  end
  else
  begin : g_chain
    logic [STAGES-1:0] valid_q;
    logic [WIDTH-1:0]  data_q [STAGES];

    always_ff @(posedge clk_i)
    begin
      if (!rst_n_i)
        valid_q <= '0;
      else
      begin
        valid_q[0] <= valid_i;
        for (int i = 1; i < STAGES; i++)
          valid_q[i] <= valid_q[i-1];
      end
    end

    always_ff @(posedge clk_i)
    begin
      data_q[0] <= data_i;
      for (int i = 1; i < STAGES; i++)
        data_q[i] <= data_q[i-1];
    end

    assign valid_o = valid_q[STAGES-1];
    assign data_o  = data_q[STAGES-1];
  end

endmodule

/* logic/fix_fma_pipe.sv */
// Fixed-point fused multiply-add pipe for signed Q16.16, or Q8.8 when narrow.
// Narrow operands are taken from the low half word. The result is rounded by the
// resolved mode, saturated and sign-extended, with inexact and overflow flags.
// Latency is LAT cycles: one input register, then LAT-1 delay stages.
module fix_fma_pipe #(
  parameter int LAT = 3
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  mac_pkg::fma_req_t  req_i,
  output logic               valid_o,
  output mac_pkg::pipe_res_t res_o
);

  localparam int DATA_W = $bits(mac_pkg::data_t);
  localparam int HALF_W = DATA_W / 2;
  localparam int PROD_W = 2 * DATA_W;
  // two spare bits above the product so negation and the addend never wrap
  localparam int SUM_W  = PROD_W + 2;
  localparam int SH_W   = $clog2(SUM_W);

  typedef logic signed [SUM_W-1:0] acc_t;

  mac_pkg::fma_req_t        req_q;
  logic                     valid_q;
  logic signed [DATA_W-1:0] op_a;
  logic signed [DATA_W-1:0] op_b;
  logic signed [DATA_W-1:0] op_c;
  logic signed [PROD_W-1:0] prod;
  logic [SH_W-1:0]          frac_sh;
  logic [SH_W-1:0]          sat_sh;
  acc_t                     prod_s;
  acc_t                     addend_s;
  acc_t                     sum;
  acc_t                     floor_v;
  acc_t                     rounded;
  acc_t                     max_v;
  acc_t                     min_v;
  acc_t                     sat_v;
  logic [SUM_W-1:0]         disc_mask;
  logic                     guard;
  logic                     sticky;
  logic                     inexact;
  logic                     round_up;
  logic                     overflow;
  mac_pkg::pipe_res_t       res_d;

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
      valid_q <= 1'b0;
    else
      valid_q <= valid_i;
  end

  always_ff @(posedge clk_i)
  begin
    req_q <= req_i;
  end

  always_comb
  begin
    if (req_q.narrow)
    begin
      op_a    = {{HALF_W{req_q.a[HALF_W-1]}}, req_q.a[HALF_W-1:0]};
      op_b    = {{HALF_W{req_q.b[HALF_W-1]}}, req_q.b[HALF_W-1:0]};
      op_c    = {{HALF_W{req_q.c[HALF_W-1]}}, req_q.c[HALF_W-1:0]};
      frac_sh = SH_W'(mac_pkg::FRAC_W / 2);
      sat_sh  = SH_W'(HALF_W - 1);
    end
    else
    begin
      op_a    = req_q.a;
      op_b    = req_q.b;
      op_c    = req_q.c;
      frac_sh = SH_W'(mac_pkg::FRAC_W);
      sat_sh  = SH_W'(DATA_W - 1);
    end

    // product carries twice the fraction bits, so the addend is aligned up to match
    prod   = op_a * op_b;
    prod_s = prod;
    if (req_q.ctl.neg_prod)
      prod_s = -prod_s;
    addend_s = acc_t'(op_c) <<< frac_sh;
    if (req_q.ctl.no_addend)
      addend_s = '0;
    else if (req_q.ctl.neg_addend)
      addend_s = -addend_s;
    sum = prod_s + addend_s;

    // arithmetic shift gives round-down, the other modes add one on top of it
    floor_v   = sum >>> frac_sh;
    disc_mask = (SUM_W'(1) << frac_sh) - SUM_W'(1);
    inexact   = |(sum & disc_mask);
    guard     = sum[frac_sh - 1];
    sticky    = |(sum & (disc_mask >> 1));
    case (req_q.rm)
      mac_pkg::e_rtz: round_up = sum[SUM_W-1] & inexact;
      mac_pkg::e_rdn: round_up = 1'b0;
      mac_pkg::e_rup: round_up = inexact;
      default:        round_up = guard & (sticky | floor_v[0]);
    endcase
    rounded = floor_v + acc_t'(round_up);

    // the inverted maximum is the most negative value of the same format
    max_v    = (acc_t'(1) <<< sat_sh) - acc_t'(1);
    min_v    = ~max_v;
    overflow = (rounded > max_v) || (rounded < min_v);
    if (!overflow)
      sat_v = rounded;
    else if (rounded[SUM_W-1])
      sat_v = min_v;
    else
      sat_v = max_v;

    // a clamped narrow value is already sign-extended in the low word
    res_d.tag            = req_q.tag;
    res_d.data           = sat_v[DATA_W-1:0];
    res_d.flags.inexact  = inexact;
    res_d.flags.overflow = overflow;
  end

  pipe_delay #(
    .STAGES(LAT - 1),
    .WIDTH ($bits(mac_pkg::pipe_res_t))
  ) u_delay (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(valid_q),
    .data_i (res_d),
    .valid_o(valid_o),
    .data_o (res_o)
  );

endmodule

/* logic/imul_pipe.sv */
// Integer multiply pipe returning the low word of the product.
// In word mode the low half word is kept and sign-extended. Flags are always
// clear; the result appears LAT cycles after the request.
module imul_pipe #(
  parameter int LAT = 2
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               valid_i,
  input  mac_pkg::imul_req_t req_i,
  output logic               valid_o,
  output mac_pkg::pipe_res_t res_o
);

  localparam int HALF_W = $bits(mac_pkg::data_t) / 2;

  mac_pkg::data_t     prod_lo;
  mac_pkg::pipe_res_t res_d;

  // low product bits are the same for signed and unsigned operands
  assign prod_lo = req_i.a * req_i.b;

  always_comb
  begin
    res_d.tag   = req_i.tag;
    res_d.flags = '0;
    if (req_i.word)
      res_d.data = {{HALF_W{prod_lo[HALF_W-1]}}, prod_lo[HALF_W-1:0]};
    else
      res_d.data = prod_lo;
  end

  pipe_delay #(
    .STAGES(LAT),
    .WIDTH ($bits(mac_pkg::pipe_res_t))
  ) u_delay (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(valid_i),
    .data_i (res_d),
    .valid_o(valid_o),
    .data_o (res_o)
  );

endmodule

/* logic/result_merge.sv */
// Result merge for both pipes.
// Arriving results are written into a circular buffer, imul first when both arrive
// together. The oldest entry is sent to the consumer one cycle later if a consumer
// credit is held, and each delivered result returns one issue credit.
module result_merge #(
  parameter int DEPTH = 4
) (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               fma_valid_i,
  input  mac_pkg::pipe_res_t fma_res_i,
  input  logic               imul_valid_i,
  input  mac_pkg::pipe_res_t imul_res_i,
  input  logic               res_credit_i,
  output logic               res_valid_o,
  output mac_pkg::pipe_res_t res_o,
  output logic               issue_credit_o
);

  localparam int PTR_W  = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);
  localparam int CRED_W = 8;

  typedef logic [PTR_W-1:0]  ptr_t;
  typedef logic [CNT_W-1:0]  cnt_t;
  typedef logic [CRED_W-1:0] cred_t;

  mac_pkg::pipe_res_t buf_mem [DEPTH];
  ptr_t               rd_ptr_q;
  ptr_t               wr_ptr_q;
  ptr_t               wr_ptr_2nd;
  cnt_t               count_q;
  cred_t              credit_cnt_q;
  logic [1:0]         n_wr;
  logic               have_entry;
  logic               pop;
  mac_pkg::pipe_res_t head;
  mac_pkg::pipe_res_t res_q;
  logic               res_valid_q;
  logic               issue_credit_q;

  function automatic ptr_t ptr_inc(input ptr_t p);
    return (p == ptr_t'(DEPTH - 1)) ? '0 : p + 1'b1;
  endfunction

  assign n_wr       = {1'b0, imul_valid_i} + {1'b0, fma_valid_i};
  assign wr_ptr_2nd = ptr_inc(wr_ptr_q);

  // with an empty buffer the arriving result bypasses straight to the output
  assign have_entry = (count_q != '0) | imul_valid_i | fma_valid_i;
  assign head       = (count_q != '0) ? buf_mem[rd_ptr_q]
                    : (imul_valid_i ? imul_res_i : fma_res_i);
  assign pop        = have_entry & (credit_cnt_q != '0);

  always_ff @(posedge clk_i)
  begin
    if (imul_valid_i)
      buf_mem[wr_ptr_q] <= imul_res_i;
    if (fma_valid_i)
      buf_mem[imul_valid_i ? wr_ptr_2nd : wr_ptr_q] <= fma_res_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      rd_ptr_q       <= '0;
      wr_ptr_q       <= '0;
      count_q        <= '0;
      credit_cnt_q   <= '0;
      res_valid_q    <= 1'b0;
      issue_credit_q <= 1'b0;
    end
    else
    begin
      if (n_wr == 2'd2)
        wr_ptr_q <= ptr_inc(wr_ptr_2nd);
      else if (n_wr == 2'd1)
        wr_ptr_q <= wr_ptr_2nd;
      if (pop)
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      count_q        <= count_q + cnt_t'(n_wr) - cnt_t'(pop);
      credit_cnt_q   <= credit_cnt_q + cred_t'(res_credit_i) - cred_t'(pop);
      res_valid_q    <= pop;
      issue_credit_q <= pop;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (pop)
      res_q <= head;
  end

  assign res_valid_o    = res_valid_q;
  assign res_o          = res_q;
  assign issue_credit_o = issue_credit_q;

endmodule

/* logic/mac_pipe_top.sv */
// Top level of the multiply-add execution pipe.
// The decoder feeds the fixed-point and integer pipes side by side; the merge
// orders their results and runs credit flow control toward issuer and consumer.
module mac_pipe_top #(
  parameter int FMA_LAT   = 3,
  parameter int IMUL_LAT  = 2,
  parameter int BUF_DEPTH = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   issue_valid_i,
  input  mac_pkg::dispatch_pkt_t issue_pkt_i,
  input  mac_pkg::rm_e           frm_dyn_i,
  output logic                   issue_credit_o,
  input  logic                   res_credit_i,
  output logic                   res_valid_o,
  output mac_pkg::pipe_res_t     res_o
);

  logic               fma_req_valid;
  mac_pkg::fma_req_t  fma_req;
  logic               imul_req_valid;
  mac_pkg::imul_req_t imul_req;
  logic               fma_res_valid;
  mac_pkg::pipe_res_t fma_res;
  logic               imul_res_valid;
  mac_pkg::pipe_res_t imul_res;

  dispatch_decode u_decode (
    .pkt_i       (issue_pkt_i),
    .valid_i     (issue_valid_i),
    .frm_dyn_i   (frm_dyn_i),
    .fma_valid_o (fma_req_valid),
    .fma_req_o   (fma_req),
    .imul_valid_o(imul_req_valid),
    .imul_req_o  (imul_req)
  );

  fix_fma_pipe #(.LAT(FMA_LAT)) u_fma (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(fma_req_valid),
    .req_i  (fma_req),
    .valid_o(fma_res_valid),
    .res_o  (fma_res)
  );

  imul_pipe #(.LAT(IMUL_LAT)) u_imul (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(imul_req_valid),
    .req_i  (imul_req),
    .valid_o(imul_res_valid),
    .res_o  (imul_res)
  );

  result_merge #(.DEPTH(BUF_DEPTH)) u_merge (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .fma_valid_i   (fma_res_valid),
    .fma_res_i     (fma_res),
    .imul_valid_i  (imul_res_valid),
    .imul_res_i    (imul_res),
    .res_credit_i  (res_credit_i),
    .res_valid_o   (res_valid_o),
    .res_o         (res_o),
    .issue_credit_o(issue_credit_o)
  );

endmodule

/* dv/mac_pipe_asserts.sv */
// Concurrent checks on the result merge, bound into result_merge by the testbench.
// Covers consumer credit, buffer bounds, issue credit pairing and quiet outputs
// after reset. Failures are counted so the testbench can fold them into its verdict.
module mac_pipe_asserts #(
  parameter int DEPTH = 4
) (
  input logic                       clk_i,
  input logic                       rst_n_i,
  input logic [$clog2(DEPTH+1)-1:0] count_i,
  input logic [7:0]                 credit_cnt_i,
  input logic [1:0]                 n_wr_i,
  input logic                       res_valid_i,
  input logic                       issue_credit_i
);
  timeunit 1ns;
  timeprecision 100ps;

  int unsigned fail_cnt = 0;
  logic        in_reset_q;

  always_ff @(posedge clk_i)
    in_reset_q <= !rst_n_i;

  // a delivered result spent a credit that was held in the cycle before
  credit_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    res_valid_i |-> $past(credit_cnt_i) != '0)
    else begin fail_cnt++; $error("result delivered without consumer credit"); end

  occupancy_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    32'(count_i) <= DEPTH)
    else begin fail_cnt++; $error("merge buffer holds more than DEPTH entries"); end

  no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    32'(count_i) + 32'(n_wr_i) <= DEPTH)
    else begin fail_cnt++; $error("merge buffer written while full"); end

  credit_with_result: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    issue_credit_i |-> res_valid_i)
    else begin fail_cnt++; $error("issue credit returned without a result"); end

  // first cycle out of reset
  quiet_after_reset: assert property (@(posedge clk_i)
    (in_reset_q && rst_n_i) |-> (!res_valid_i && !issue_credit_i && count_i == '0))
    else begin fail_cnt++; $error("merge outputs active right after reset"); end

endmodule

/* dv/mac_pipe_tb.sv */
// Testbench for the multiply-add execution pipe.
// Issues packets under issue credits, grants random consumer credits and checks each
// result against a model kept per tag. Assertions bound into the merge watch the
// credit protocol; their failure count is part of the closing report.
module mac_pipe_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int BUF_DEPTH  = 4;
  localparam int TIMEOUT    = 300;
  // results the consumer can have granted but not yet received
  localparam int CONS_SLOTS = 3;

  logic                   clk;
  logic                   rst_n;
  logic                   issue_valid;
  mac_pkg::dispatch_pkt_t issue_pkt;
  mac_pkg::rm_e           frm_dyn;
  logic                   issue_credit;
  logic                   res_credit;
  logic                   res_valid;
  mac_pkg::pipe_res_t     res;

  mac_pkg::data_t  exp_data [16];
  mac_pkg::flags_t exp_flags [16];
  logic            exp_live [16];
  int              issued;
  int              returned;
  int              cons_open;
  int              credit_pct;
  int              n_checked;
  int              n_errors;
  mac_pkg::tag_t   next_tag;
  // once a wait has timed out, no further packets are issued or waited for
  logic            timed_out;

  mac_pipe_top #(
    .FMA_LAT  (3),
    .IMUL_LAT (2),
    .BUF_DEPTH(BUF_DEPTH)
  ) u_dut (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .issue_valid_i (issue_valid),
    .issue_pkt_i   (issue_pkt),
    .frm_dyn_i     (frm_dyn),
    .issue_credit_o(issue_credit),
    .res_credit_i  (res_credit),
    .res_valid_o   (res_valid),
    .res_o         (res)
  );

  bind result_merge mac_pipe_asserts #(.DEPTH(DEPTH)) u_asserts (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .count_i       (count_q),
    .credit_cnt_i  (credit_cnt_q),
    .n_wr_i        (n_wr),
    .res_valid_i   (res_valid_o),
    .issue_credit_i(issue_credit_o)
  );

  always #4 clk = ~clk;

  function automatic longint fix_val(input mac_pkg::data_t w, input logic narrow);
    if (narrow)
      return longint'($signed(w[15:0]));
    return longint'($signed(w));
  endfunction

  // exact result scaled by 2^(2*frac), then rounded to frac bits and clamped
  function automatic void fix_model(input mac_pkg::dispatch_pkt_t p, input mac_pkg::rm_e rm,
                                    output mac_pkg::data_t d, output mac_pkg::flags_t f);
    int     frac;
    longint a;
    longint b;
    longint c;
    longint sum;
    longint q;
    longint rem;
    longint lim;
    logic   up;
    frac = p.narrow ? 8 : 16;
    lim  = (longint'(1) <<< (p.narrow ? 15 : 31)) - 1;
    a    = fix_val(p.rs1, p.narrow);
    b    = fix_val(p.rs2, p.narrow);
    c    = fix_val(p.rs3, p.narrow) <<< frac;
    case (p.op)
      mac_pkg::e_op_fadd:   sum = (a <<< frac) + (b <<< frac);
      mac_pkg::e_op_fsub:   sum = (a <<< frac) - (b <<< frac);
      mac_pkg::e_op_fmul:   sum = a * b;
      mac_pkg::e_op_fmadd:  sum = a * b + c;
      mac_pkg::e_op_fmsub:  sum = a * b - c;
      mac_pkg::e_op_fnmsub: sum = c - a * b;
      default:              sum = -(a * b) - c;
    endcase
    q   = sum >>> frac;
    rem = sum - (q <<< frac);
    case (rm)
      mac_pkg::e_rtz: up = (sum < 0) && (rem != 0);
      mac_pkg::e_rdn: up = 1'b0;
      mac_pkg::e_rup: up = (rem != 0);
      default:        up = (rem > (longint'(1) <<< (frac - 1))) ||
                           ((rem == (longint'(1) <<< (frac - 1))) && q[0]);
    endcase
    q          = q + longint'(up);
    f.inexact  = (rem != 0);
    f.overflow = (q > lim) || (q < -lim - 1);
    if (q > lim)
      q = lim;
    else if (q < -lim - 1)
      q = -lim - 1;
    d = mac_pkg::data_t'(q);
  endfunction

  function automatic mac_pkg::data_t imul_model(input mac_pkg::dispatch_pkt_t p);
    longint prod;
    prod = longint'($signed(p.rs1)) * longint'($signed(p.rs2));
    if (p.narrow)
      return mac_pkg::data_t'(longint'($signed(prod[15:0])));
    return prod[31:0];
  endfunction

  // moderate Q16.16 value, roughly within +-8.0
  function automatic mac_pkg::data_t small_fix();
    return mac_pkg::data_t'($signed($urandom) >>> 12);
  endfunction

  task automatic finish_run();
    int assert_fails;
    assert_fails = u_dut.u_merge.u_asserts.fail_cnt;
    $display("results checked %0d, errors %0d, assertion failures %0d",
             n_checked, n_errors, assert_fails);
    if (n_errors == 0 && assert_fails == 0)
      $display("test passed");
    else
      $display("test failed");
    $finish;
  endtask

  task automatic compare(input string name, input mac_pkg::data_t exp, input mac_pkg::data_t act);
    if (exp !== act)
    begin
      n_errors++;
      $display("error at %0d ns: %s expected %h, got %h", $time, name, exp, act);
    end
  endtask

  // check outputs at the falling edge, then drive inputs just after the rising edge
  task automatic cycle_step();
    @(negedge clk);
    if (issue_credit)
    begin
      if (returned >= issued)
      begin
        n_errors++;
        $display("issue credit returned at %0d ns with nothing outstanding", $time);
      end
      returned++;
    end
    if (res_valid)
    begin
      n_checked++;
      if (cons_open == 0)
      begin
        n_errors++;
        $display("result delivered at %0d ns without a consumer credit", $time);
      end
      else
        cons_open--;
      if (!exp_live[res.tag])
      begin
        n_errors++;
        $display("unexpected result with tag %0d at %0d ns", res.tag, $time);
      end
      else
      begin
        exp_live[res.tag] = 1'b0;
        compare("res_o.data", exp_data[res.tag], res.data);
        compare("res_o.flags", mac_pkg::data_t'(exp_flags[res.tag]),
                mac_pkg::data_t'(res.flags));
      end
    end
    @(posedge clk);
    #1;
    issue_valid = 1'b0;
    res_credit  = (cons_open < CONS_SLOTS) && (int'($urandom_range(99)) < credit_pct);
    if (res_credit)
      cons_open++;
  endtask

  task automatic issue(input mac_pkg::mac_op_e op, input mac_pkg::rm_e rm, input logic narrow,
                       input mac_pkg::data_t rs1, input mac_pkg::data_t rs2,
                       input mac_pkg::data_t rs3);
    mac_pkg::dispatch_pkt_t p;
    int                     waited;
    waited = 0;
    while (!timed_out && (issued - returned >= BUF_DEPTH))
    begin
      waited++;
      if (waited > TIMEOUT)
      begin
        n_errors++;
        timed_out = 1'b1;
        $display("no issue credit came back within %0d cycles", TIMEOUT);
      end
      else
        cycle_step();
    end
    if (!timed_out)
    begin
      p = '{op, rm, narrow, next_tag, rs1, rs2, rs3};
      exp_live[p.tag] = 1'b1;
      if (op == mac_pkg::e_op_imul)
      begin
        exp_data[p.tag]  = imul_model(p);
        exp_flags[p.tag] = '0;
      end
      else
        fix_model(p, (rm == mac_pkg::e_dyn) ? frm_dyn : rm, exp_data[p.tag], exp_flags[p.tag]);
      issue_pkt   = p;
      issue_valid = 1'b1;
      issued++;
      next_tag++;
      cycle_step();
    end
  endtask

  task automatic issue_random(input int n);
    for (int i = 0; i < n; i++)
      issue(mac_pkg::mac_op_e'($urandom_range(7)), mac_pkg::rm_e'($urandom_range(3)),
            1'($urandom_range(1)), small_fix(), small_fix(), $urandom);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while (!timed_out && (issued != returned))
    begin
      waited++;
      if (waited > TIMEOUT)
      begin
        n_errors++;
        timed_out = 1'b1;
        $display("%0d results still outstanding after %0d cycles", issued - returned, TIMEOUT);
      end
      else
        cycle_step();
    end
  endtask

  // eight cycles of reset; everything in flight is forgotten
  task automatic apply_reset();
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    res_credit  = 1'b0;
    repeat (8) @(posedge clk);
    #1;
    rst_n     = 1'b1;
    issued    = 0;
    returned  = 0;
    cons_open = 0;
    for (int t = 0; t < 16; t++)
      exp_live[t] = 1'b0;
  endtask

  initial
  begin
    mac_pkg::rm_e rm;
    clk         = 1'b0;
    rst_n       = 1'b0;
    issue_valid = 1'b0;
    issue_pkt   = '0;
    frm_dyn     = mac_pkg::e_rne;
    res_credit  = 1'b0;
    n_errors    = 0;
    n_checked   = 0;
    next_tag    = '0;
    credit_pct  = 100;
    timed_out   = 1'b0;
    void'($urandom(32'h2829));
    apply_reset();

    // integer multiply, full and word mode, negative operands included
    issue(mac_pkg::e_op_imul, mac_pkg::e_rne, 1'b0, 32'hfffffffd, 32'h00012345, '0);
    issue(mac_pkg::e_op_imul, mac_pkg::e_rne, 1'b1, 32'hffff8001, 32'h00000003, '0);
    for (int i = 0; i < 6; i++)
      issue(mac_pkg::e_op_imul, mac_pkg::e_rne, 1'(i), $urandom, $urandom, '0);
    drain();

    // every fixed-point op in every mode; the last mode is dyn with a changing frm
    for (int op = 0; op < 7; op++)
      for (int m = 0; m < 5; m++)
      begin
        rm      = (m == 4) ? mac_pkg::e_dyn : mac_pkg::rm_e'(m);
        frm_dyn = mac_pkg::rm_e'(op % 4);
        issue(mac_pkg::mac_op_e'(op), rm, 1'b0, small_fix(), small_fix(), small_fix());
        // 3 x 2^-16 times one half lands exactly on a rounding tie
        issue(mac_pkg::mac_op_e'(op), rm, 1'b0, 32'h00000003, 32'h00008000, 32'h00000001);
      end
    drain();

    // narrow format and saturation at both format limits
    issue(mac_pkg::e_op_fmul, mac_pkg::e_rne, 1'b1, 32'h00007f00, 32'h00007f00, '0);
    issue(mac_pkg::e_op_fmul, mac_pkg::e_rne, 1'b1, 32'h00008000, 32'h00007f00, '0);
    issue(mac_pkg::e_op_fadd, mac_pkg::e_rdn, 1'b1, 32'h00007fff, 32'h00000001, '0);
    issue(mac_pkg::e_op_fmadd, mac_pkg::e_rup, 1'b1, 32'h00000180, 32'h00000081, 32'h0000fff0);
    issue(mac_pkg::e_op_fmul, mac_pkg::e_rtz, 1'b0, 32'h7fff0000, 32'h00020000, '0);
    issue(mac_pkg::e_op_fmsub, mac_pkg::e_rne, 1'b0, 32'h80000000, 32'h00010000, 32'h00010000);
    for (int i = 0; i < 6; i++)
      issue(mac_pkg::mac_op_e'($urandom_range(6)), mac_pkg::e_rne, 1'b1, $urandom, $urandom,
            $urandom);
    drain();

    // alternating pipes so that both finish in the same cycle
    for (int i = 0; i < 8; i++)
    begin
      issue(mac_pkg::e_op_fmadd, mac_pkg::e_rne, 1'b0, small_fix(), small_fix(), small_fix());
      issue(mac_pkg::e_op_imul, mac_pkg::e_rne, 1'b0, $urandom, $urandom, '0);
    end
    drain();

    // sparse consumer credits keep results waiting in the merge buffer
    credit_pct = 10;
    issue_random(20);
    drain();

    // reset with traffic in flight, then nothing may come out until new issues
    credit_pct = 30;
    issue_random(4);
    apply_reset();
    credit_pct = 100;
    repeat (12) cycle_step();
    issue_random(10);
    drain();

    for (int t = 0; t < 16; t++)
      if (exp_live[t])
      begin
        n_errors++;
        $display("tag %0d was issued but never returned", t);
      end
    finish_run();
  end

endmodule

/* src.f */
logic/mac_pkg.sv
logic/dispatch_decode.sv
logic/pipe_delay.sv
logic/fix_fma_pipe.sv
logic/imul_pipe.sv
logic/result_merge.sv
logic/mac_pipe_top.sv
dv/mac_pipe_asserts.sv
dv/mac_pipe_tb.sv

/* Makefile */
# Verilator build and run for the multiply-add pipe testbench.
# Any variable can be overridden on the command line, e.g. make run BUILD_DIR=out

VERILATOR ?= verilator
TOP       ?= mac_pipe_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= test passed

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
